/* build.sh */
#!/bin/sh
# builds the sandbox testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sandboxTop_tb -f project.f -o sandboxSim; then
  echo "verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/sandboxSim 2>&1); then
  echo "$output"
  echo "simulation exited with an error status"
  exit 1
fi

echo "$output"

if echo "$output" | grep -qxF '** PASS **'; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* logic/activityIndicator.sv */
// activityIndicator: receive LED pulse stretcher, lit for one slowClock period per start
module activityIndicator
(
  input  logic masterClock,
  input  logic reset,       // sync, active low
  input  logic slowClock,   // sampled as a level, no sync stage
  input  logic startPulse,  // one-cycle command start
  output logic rxIndicator  // LED drive
);

  // ------------------------------
  // state encoding
  // ------------------------------
  typedef enum logic [2:0]
  {
    stateIdle,    // LED off, accepting starts
    stateArmed,   // start seen, wait for slowClock high
    stateRise,    // slowClock high, wait for its fall
    stateLit,     // LED on, wait for slowClock high
    stateLitRise  // LED on, wait for the fall that ends it
  } indicatorStateT;

  indicatorStateT state;

  // starts during any state but idle are dropped
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state       <= stateIdle;
      rxIndicator <= 1'b0;
    end
    else
    begin
      case (state)
        stateIdle:
          if (startPulse)
            state <= stateArmed;

        stateArmed:
          if (slowClock)
            state <= stateRise;

        stateRise:
          if (!slowClock)
          begin
            rxIndicator <= 1'b1; // first full slow cycle done
            state       <= stateLit;
          end

        stateLit:
          if (slowClock)
            state <= stateLitRise;

        stateLitRise:
          if (!slowClock)
          begin
            rxIndicator <= 1'b0; // one slow period lit
            state       <= stateIdle;
          end

        default:
        begin
          rxIndicator <= 1'b0;
          state       <= stateIdle;
        end
      endcase
    end
  end

endmodule

/* logic/esfaStore.sv */
// esfaStore: indexed register store of value/metadata entries with valid flags and range check
module esfaStore
#(
  parameter int storeDepth = esfaStorePkg::defaultStoreDepth
)
(
  input  logic                     masterClock,
  input  logic                     reset,          // sync, active low
  input  logic                     opStrobe,       // one operation per pulse
  input  logic                     updateOp,       // 1 = update, 0 = query
  input  logic                     writeValue,
  input  logic                     writeMetadata,
  input  logic                     selectMetadata, // query reads metadata
  input  esfaStorePkg::storeIndexT entryIndex,
  input  esfaStorePkg::storeByteT  newValue,
  input  esfaStorePkg::storeByteT  newMetadata,
  output logic                     resultBool,
  output esfaStorePkg::storeByteT  resultValue
);

  import esfaStorePkg::*;

  // slot address bits, at least one so a single entry still works
  localparam int slotWidth = (storeDepth > 1) ? $clog2(storeDepth) : 1;

  // ------------------------------
  // entry storage
  // ------------------------------
  storeByteT valueMem [storeDepth];
  storeByteT metaMem  [storeDepth];
  logic      validMem [storeDepth]; // set by first write of either field

  logic                 inRange;    // index below depth
  logic                 entryValid; // in range and written
  logic [slotWidth-1:0] slot;

  assign inRange    = (int'(entryIndex) < storeDepth);
  assign slot       = entryIndex[slotWidth-1:0]; // only meaningful when inRange
  assign entryValid = inRange && validMem[slot];

  // ------------------------------
  // operations
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      for (int i = 0; i < storeDepth; i++)
      begin
        valueMem[i] <= '0;
        metaMem[i]  <= '0;
        validMem[i] <= 1'b0;
      end
      resultBool  <= 1'b0;
      resultValue <= '0;
    end
    else if (opStrobe)
    begin
      if (updateOp)
      begin
        resultBool  <= inRange; // ack only, no data back
        resultValue <= '0;
        if (inRange)
        begin
          if (writeValue)
            valueMem[slot] <= newValue;
          if (writeMetadata)
            metaMem[slot] <= newMetadata;
          if (writeValue || writeMetadata)
            validMem[slot] <= 1'b1;
        end
      end
      else
      begin
        resultBool <= entryValid;
        if (!entryValid)
          resultValue <= '0; // unwritten or out of range
        else if (selectMetadata)
          resultValue <= metaMem[slot];
        else
          resultValue <= valueMem[slot];
      end
    end
  end

endmodule

/* logic/esfaStorePkg.sv */
// store definitions: entry index and field types, default entry count
package esfaStorePkg;

  // ------------------------------
  // field types
  // ------------------------------
  // command word layout, as split by the sequencer
  //   bits  7..0  entry index
  //   bits 15..8  new value
  //   bits 23..16 new metadata
  //   bits 31..24 selector, bit 0 used
  localparam int storeIndexWidth = 8; // wide enough for any depth up to 256
  localparam int storeByteWidth  = 8; // value and metadata share one width

  typedef logic [storeIndexWidth-1:0] storeIndexT; // entry number from host
  typedef logic [storeByteWidth-1:0]  storeByteT;  // one value or metadata field

  // ------------------------------
  // sizing
  // ------------------------------
  // indices at or above the depth are out of range
  // and answer with a clear result flag
  localparam int defaultStoreDepth = 16; // entries held when top level keeps default

endpackage

/* logic/sandboxLinkPkg.sv */
// host link definitions: control/status bit positions, command and response word types
package sandboxLinkPkg;

  // ------------------------------
  // word widths
  // ------------------------------
  localparam int controlWidth  = 8;  // control byte from host
  localparam int statusWidth   = 8;  // status byte back to host
  localparam int dataWordWidth = 32; // data word, both directions

  typedef logic [controlWidth-1:0]  controlT;  // host control byte
  typedef logic [statusWidth-1:0]   statusT;   // returned status byte
  typedef logic [dataWordWidth-1:0] dataWordT; // command word in, response word out

  // ------------------------------
  // control byte bit positions
  // ------------------------------
  // bit 0 picks the command kind
  // update commands use bits 2 and 1 as field write enables
  localparam int ctlRequestBit  = 0; // 1 = update, 0 = query
  localparam int ctlMetadataBit = 1; // update writes metadata field
  localparam int ctlValueBit    = 2; // update writes value field

  // ------------------------------
  // status byte bit positions
  // ------------------------------
  // all other status bits read as zero
  localparam int statusResultBit = 0; // store result flag

endpackage

/* logic/sandboxProcess.sv */
// sandboxProcess: host command sequencer, store operation issue, result capture and handshake
module sandboxProcess
(
  input  logic                     masterClock,
  input  logic                     reset,          // sync, active low
  input  logic                     dataReceived,   // host has a command waiting
  input  sandboxLinkPkg::controlT  control,        // command kind and write enables
  input  sandboxLinkPkg::dataWordT inputData,      // index, value, metadata, selector
  input  logic                     resultBool,     // store flag, registered
  input  esfaStorePkg::storeByteT  resultValue,    // store field, registered
  output logic                     clearDR,        // command consumed
  output logic                     transmitData,   // response ready for host
  output sandboxLinkPkg::statusT   status,
  output sandboxLinkPkg::dataWordT outputData,
  output logic                     opStrobe,       // one-cycle store request
  output logic                     startPulse,     // one-cycle activity event
  output logic                     updateOp,       // 1 = update, 0 = query
  output logic                     writeValue,
  output logic                     writeMetadata,
  output logic                     selectMetadata, // query reads metadata
  output esfaStorePkg::storeIndexT entryIndex,
  output esfaStorePkg::storeByteT  newValue,
  output esfaStorePkg::storeByteT  newMetadata
);

  import sandboxLinkPkg::*;

  // ------------------------------
  // state encoding
  // ------------------------------
  typedef enum logic [2:0]
  {
    stateIdle,    // waiting for dataReceived
    stateIssue,   // store strobe cycle
    stateWait,    // store result lands this cycle
    stateReport,  // response up, counting to clearDR
    stateHold,    // raise clearDR
    stateRelease  // wait for host to drop dataReceived
  } processStateT;

  processStateT state;
  logic         issuing; // decode of issue state

  // strobe and activity event come out of the same cycle
  assign issuing    = (state == stateIssue);
  assign opStrobe   = issuing;
  assign startPulse = issuing;

  // ------------------------------
  // command split
  // ------------------------------
  // operation fields, loaded once per command and held until the next
  always_ff @(posedge masterClock)
  begin
    if ((state == stateIdle) && dataReceived)
    begin
      updateOp       <= control[ctlRequestBit];
      writeValue     <= control[ctlValueBit];
      writeMetadata  <= control[ctlMetadataBit];
      entryIndex     <= inputData[7:0];   // index field
      newValue       <= inputData[15:8];  // value field
      newMetadata    <= inputData[23:16]; // metadata field
      selectMetadata <= inputData[24];    // selector bit 0
    end
  end

  // ------------------------------
  // sequencer and host handshake
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state        <= stateIdle;
      status       <= '0;
      outputData   <= '0;
      transmitData <= 1'b0;
      clearDR      <= 1'b0;
    end
    else
    begin
      case (state)
        stateIdle:
        begin
          if (dataReceived)
          begin
            state <= stateIssue; // fields latch on this edge too
          end
        end

        stateIssue:
        begin
          state <= stateWait; // store samples the strobe here
        end

        stateWait:
        begin
          // result registered one cycle after the strobe, valid now
          status                  <= '0;
          status[statusResultBit] <= resultBool;
          outputData              <= {{(dataWordWidth - 8){1'b0}}, resultValue};
          transmitData            <= 1'b1; // response is stable from here
          state                   <= stateReport;
        end

        stateReport:
        begin
          state <= stateHold; // spacer, clearDR trails transmitData by two
        end

        stateHold:
        begin
          clearDR <= 1'b1; // host may now drop dataReceived
          state   <= stateRelease;
        end

        stateRelease:
        begin
          if (!dataReceived)
          begin
            transmitData <= 1'b0;
            clearDR      <= 1'b0;
            state        <= stateIdle;
          end
        end

        default:
        begin
          state        <= stateIdle;
          transmitData <= 1'b0;
          clearDR      <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* logic/sandboxTop.sv */
// sandboxTop: host-facing sandbox, wires command sequencer, entry store and activity LED
module sandboxTop
#(
  parameter int storeDepth = esfaStorePkg::defaultStoreDepth // entries in the store
)
(
  input  logic                     masterClock,
  input  logic                     slowClock,    // LED timing, plain level
  input  logic                     reset,        // sync, active low
  input  logic                     dataReceived,
  input  sandboxLinkPkg::controlT  control,
  input  sandboxLinkPkg::dataWordT inputData,
  output logic                     clearDR,
  output logic                     transmitData,
  output sandboxLinkPkg::statusT   status,
  output sandboxLinkPkg::dataWordT outputData,
  output logic                     rxIndicator
);

  import esfaStorePkg::*;

  // ------------------------------
  // process to store
  // ------------------------------
  logic       opStrobe;
  logic       updateOp;
  logic       writeValue;
  logic       writeMetadata;
  logic       selectMetadata;
  storeIndexT entryIndex;
  storeByteT  newValue;
  storeByteT  newMetadata;

  // store to process, registered
  logic      resultBool;
  storeByteT resultValue;

  logic startPulse; // process to indicator

  // producer, also consumer of store results
  sandboxProcess processInst
  (
    .masterClock    (masterClock),
    .reset          (reset),
    .dataReceived   (dataReceived),
    .control        (control),
    .inputData      (inputData),
    .resultBool     (resultBool),
    .resultValue    (resultValue),
    .clearDR        (clearDR),
    .transmitData   (transmitData),
    .status         (status),
    .outputData     (outputData),
    .opStrobe       (opStrobe),
    .startPulse     (startPulse),
    .updateOp       (updateOp),
    .writeValue     (writeValue),
    .writeMetadata  (writeMetadata),
    .selectMetadata (selectMetadata),
    .entryIndex     (entryIndex),
    .newValue       (newValue),
    .newMetadata    (newMetadata)
  );

  // buffer, owns the range check
  esfaStore #(.storeDepth(storeDepth)) storeInst
  (
    .masterClock    (masterClock),
    .reset          (reset),
    .opStrobe       (opStrobe),
    .updateOp       (updateOp),
    .writeValue     (writeValue),
    .writeMetadata  (writeMetadata),
    .selectMetadata (selectMetadata),
    .entryIndex     (entryIndex),
    .newValue       (newValue),
    .newMetadata    (newMetadata),
    .resultBool     (resultBool),
    .resultValue    (resultValue)
  );

  // consumer of start events
  activityIndicator indicatorInst
  (
    .masterClock (masterClock),
    .reset       (reset),
    .slowClock   (slowClock),
    .startPulse  (startPulse),
    .rxIndicator (rxIndicator)
  );

endmodule

/* project.f */
logic/sandboxLinkPkg.sv
logic/esfaStorePkg.sv
logic/sandboxProcess.sv
logic/esfaStore.sv
logic/activityIndicator.sv
logic/sandboxTop.sv
tb/sandboxTop_properties.sv
tb/sandboxTop_tb.sv

/* tb/sandboxTop_properties.sv */
// sandboxTop_properties: concurrent checks on reset levels and the host handshake, plus its bind
module sandboxTop_properties
(
  input logic                     masterClock,
  input logic                     reset,
  input logic                     dataReceived,
  input logic                     transmitData,
  input logic                     clearDR,
  input logic                     rxIndicator,
  input sandboxLinkPkg::statusT   status,
  input sandboxLinkPkg::dataWordT outputData
);

  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------
  // reset levels
  // ------------------------------
  resetQuiet: assert property (@(posedge masterClock)
    !reset |=> !transmitData && !clearDR && !rxIndicator)
    else $error("handshake or LED high after a reset edge");

  // ------------------------------
  // handshake
  // ------------------------------
  clearNeedsTransmit: assert property (@(posedge masterClock) disable iff (!reset)
    clearDR |-> transmitData)
    else $error("clearDR high without transmitData");

  // response words frozen once transmitData has been up a cycle
  responseStable: assert property (@(posedge masterClock) disable iff (!reset)
    $past(transmitData) && transmitData |-> $stable(status) && $stable(outputData))
    else $error("status or outputData moved while transmitData high");

  clearFallsAfterHost: assert property (@(posedge masterClock) disable iff (!reset)
    $fell(clearDR) |-> !$past(dataReceived))
    else $error("clearDR dropped while dataReceived still high");

endmodule

bind sandboxTop sandboxTop_properties propertiesInst (.*);

/* tb/sandboxTop_tb.sv */
// sandboxTop_tb: clocks, command stimulus, shadow store model, response compare and report
module sandboxTop_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import sandboxLinkPkg::*;
  import esfaStorePkg::*;

  localparam int tbDepth          = 16;
  localparam int slowPeriodCycles = 8;  // slowClock flips every 4 masterClock cycles
  localparam int handshakeLimit   = 20; // cycles allowed for any handshake edge
  localparam int sigTransmit      = 0;
  localparam int sigClear         = 1;
  localparam int sigIndicator     = 2;

  logic     masterClock, slowClock, reset, dataReceived;
  controlT  control;
  dataWordT inputData;
  logic     clearDR, transmitData, rxIndicator;
  statusT   status;
  dataWordT outputData;

  storeByteT shadowValue [tbDepth]; // model of the store contents
  storeByteT shadowMeta  [tbDepth];
  logic      shadowValid [tbDepth];

  int seed = 26906;
  int errorCount = 0;
  int testCount = 0;
  int errorsAtStart = 0;

  sandboxTop #(.storeDepth(tbDepth)) dut_i (.*);

  // ------------------------------
  // clocks
  // ------------------------------
  initial
  begin
    masterClock = 1'b0;
    forever #20 masterClock = ~masterClock; // 40 ns period
  end

  initial
  begin
    slowClock = 1'b0;
    forever
    begin
      repeat (4) @(negedge masterClock);
      slowClock = ~slowClock;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic dataWordT predictResponse(input controlT ctl, input dataWordT data,
                                               output statusT expStatus);
    int                         idx;
    logic                       hit;
    storeByteT                  field;
    logic [$clog2(tbDepth)-1:0] slot;
    idx = int'(data[7:0]);
    slot = data[$clog2(tbDepth)-1:0];
    hit = 1'b0;
    field = '0;
    expStatus = '0;
    if (ctl[ctlRequestBit]) // update, ack only
    begin
      hit = (idx < tbDepth);
      if (hit && ctl[ctlValueBit])
        shadowValue[slot] = data[15:8];
      if (hit && ctl[ctlMetadataBit])
        shadowMeta[slot] = data[23:16];
      if (hit && (ctl[ctlValueBit] || ctl[ctlMetadataBit]))
        shadowValid[slot] = 1'b1;
    end
    else if (idx < tbDepth)
    begin
      hit = shadowValid[slot];
      if (hit)
        field = data[24] ? shadowMeta[slot] : shadowValue[slot]; // selector bit 0
    end
    expStatus[statusResultBit] = hit;
    return {24'b0, field};
  endfunction

  // ------------------------------
  // waits and reporting
  // ------------------------------
  function automatic logic levelOf(input int which);
    case (which)
      sigTransmit: return transmitData;
      sigClear:    return clearDR;
      default:     return rxIndicator;
    endcase
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("tests %0d, errors %0d", testCount, errorCount + 1);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic waitFor(input int which, input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge masterClock);
      cycles++;
    end
    while ((levelOf(which) !== level) && (cycles < limit));
    if (levelOf(which) !== level)
      abortRun($sformatf("timeout: %s did not go %0b within %0d cycles", what, level, limit));
  endtask

  task automatic checkStatus(input string testName, input statusT expected, input statusT actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAIL %s: status expected %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic checkOutput(input string testName, input dataWordT expected,
                             input dataWordT actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAIL %s: outputData expected %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic checkLevel(input string testName, input string what, input logic expected,
                            input logic actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAIL %s: %s expected %b, actual %b", testName, what, expected, actual);
    end
  endtask

  // LED must light once and stay lit one slowClock period
  task automatic checkIndicator(input string testName);
    int width;
    waitFor(sigIndicator, 1'b1, 4 * slowPeriodCycles, "rxIndicator rise");
    width = 0;
    while ((rxIndicator === 1'b1) && (width < 2 * slowPeriodCycles))
    begin
      @(negedge masterClock);
      width++;
    end
    if (rxIndicator !== 1'b0)
      abortRun("timeout: rxIndicator stayed lit far beyond one slowClock period");
    if (width != slowPeriodCycles)
    begin
      errorCount++;
      $display("FAIL %s: LED width expected %0d, actual %0d", testName, slowPeriodCycles, width);
    end
  endtask

  task automatic finishTest(input string testName);
    testCount++;
    $display("test %s finished, %0d errors", testName, errorCount - errorsAtStart);
    errorsAtStart = errorCount;
  endtask

  // ------------------------------
  // one command, host side and compare side
  // ------------------------------
  task automatic driveCommand(input controlT ctl, input dataWordT data);
    @(negedge masterClock);
    control = ctl;
    inputData = data;
    dataReceived = 1'b1;
    waitFor(sigClear, 1'b1, handshakeLimit, "clearDR rise");
    dataReceived = 1'b0; // still on the falling edge
    waitFor(sigClear, 1'b0, handshakeLimit, "clearDR fall");
  endtask

  task automatic compareResponse(input string testName, input statusT expStatus,
                                 input dataWordT expOutput);
    waitFor(sigTransmit, 1'b1, handshakeLimit, "transmitData rise");
    checkStatus(testName, expStatus, status);
    checkOutput(testName, expOutput, outputData);
    waitFor(sigClear, 1'b1, handshakeLimit, "clearDR after transmitData");
    waitFor(sigTransmit, 1'b0, handshakeLimit, "transmitData fall");
    checkLevel(testName, "clearDR with transmitData low", 1'b0, clearDR);
  endtask

  task automatic runCommand(input string testName, input controlT ctl, input dataWordT data,
                            input bit watchLed);
    statusT   expStatus;
    dataWordT expOutput;
    expOutput = predictResponse(ctl, data, expStatus);
    fork
      driveCommand(ctl, data);
      compareResponse(testName, expStatus, expOutput);
      if (watchLed)
        checkIndicator(testName);
    join
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    controlT  ctl;
    dataWordT data;
    int       pick;
    reset = 1'b0;
    dataReceived = 1'b0;
    control = '0;
    inputData = '0;
    for (int i = 0; i < tbDepth; i++)
    begin
      shadowValue[i] = '0;
      shadowMeta[i] = '0;
      shadowValid[i] = 1'b0;
    end
    repeat (2) @(negedge masterClock);
    reset = 1'b1;

    @(negedge masterClock);
    checkLevel("reset", "transmitData", 1'b0, transmitData);
    checkLevel("reset", "clearDR", 1'b0, clearDR);
    checkLevel("reset", "rxIndicator", 1'b0, rxIndicator);
    checkStatus("reset", '0, status);
    checkOutput("reset", '0, outputData);
    finishTest("reset");

    // LED is idle here, nothing issued yet
    runCommand("indicator", 8'h07, 32'h0000_5a03, 1'b1);
    finishTest("indicator");

    for (int n = 0; n < 12; n++)
    begin
      ctl = 8'($random(seed));
      ctl[ctlRequestBit] = 1'b1;
      data = $random(seed);
      data[7:0] = 8'($random(seed) & 'h1f); // half of them out of range
      runCommand("updateAck", ctl, data, 1'b0);
    end
    finishTest("updateAck");

    for (int n = 0; n < 48; n++)
    begin
      ctl = 8'($random(seed));
      data = $random(seed);
      pick = $random(seed);
      data[7:0] = 8'((pick & 'hff) % 20); // mostly in range
      runCommand("queryAfterUpdate", ctl, data, 1'b0);
    end
    finishTest("queryAfterUpdate");

    $display("tests %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
